/* sources.f */
hdl/core_pkg.sv
hdl/bus_controller.sv
hdl/icache.sv
hdl/decode_regfile.sv
hdl/alu.sv
hdl/writeback.sv
hdl/core_top.sv
bench/core_checker.sv
bench/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := core_tb
FILELIST  := sources.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
OBJDIR    := obj_dir

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* bench/core_tb.sv */
`timescale 1ns/1ps
module core_tb;

  localparam int prog_words  = 512;
  localparam int num_retires = 2000;
  localparam int run_limit   = 200000;  // cycles allowed for the whole run
  localparam int idle_limit  = 20000;   // longest gap between bus requests
  localparam logic [63:0] prog_base = 64'h1000;

  logic clk, reset, finish_run, report_done, stalled;
  logic [63:0] entry;
  logic bus_reqcyc, bus_respack, bus_respcyc, bus_reqack;
  logic [63:0] bus_req, bus_resp;
  logic [12:0] bus_reqtag, bus_resptag;
  logic retire_valid, retire_we;
  logic [63:0] retire_pc, retire_data;
  logic [31:0] retire_inst;
  logic [4:0] retire_rd;
  logic [31:0] prog [prog_words];
  logic [31:0] rng_state = 32'd28119;
  int retires, errors;

  core_top #(.cache_lines(8), .bus_tag_width(13), .bus_data_width(64)) i_dut (.*);

  core_checker #(.cache_lines(8)) i_chk (.*);

  function automatic logic [31:0] draw();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] rand_inst();
    logic [31:0] r;
    logic [2:0] f3;
    logic [6:0] f7;
    r  = draw();
    f3 = r[14:12];
    case (draw() % 8)
      0: return {r[31:12], r[11:7], 7'b0110111};  // lui
      1: return {r[31:12], r[11:7], 7'b0010111};  // auipc
      2, 3, 4: begin
        if (f3 == 3'd1) return {6'b0, r[25:20], r[19:7], 7'b0010011};
        if (f3 == 3'd5) return {1'b0, r[30], 4'b0, r[25:20], r[19:7], 7'b0010011};
        return {r[31:7], 7'b0010011};
      end
      default: begin
        f7 = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0;  // sub, sra
        return {f7, r[24:7], 7'b0110011};
      end
    endcase
  endfunction

  function automatic logic [31:0] mem_word(input logic [63:0] addr);
    if (addr < prog_base || addr >= prog_base + 4 * prog_words) return 32'b0;
    return prog[(addr - prog_base) >> 2];
  endfunction

  // program: register prologue, random body, jal back to entry at the end
  initial begin
    int sel, tgt;
    for (int i = 1; i < 32; i++) prog[i-1] = {12'(draw()), 8'b0, 5'(i), 7'b0010011};
    for (int i = 31; i < prog_words - 1; i++) begin
      sel = draw() % 32;
      if (sel < 2) begin
        tgt = i + 1 + (draw() % (prog_words - 1 - i));  // forward, inside the program
        prog[i] = enc_jal(5'(draw()), 21'((tgt - i) * 4));
      end else if (sel == 2) prog[i] = 32'b0;
      else prog[i] = rand_inst();
    end
    prog[prog_words-1] = enc_jal(5'd0, 21'(-4 * (prog_words - 1)));
  end

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : memory_model
    int n, d, g;
    logic [63:0] addr;
    logic [12:0] tag;
    stalled = 1'b0;
    bus_reqack = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp = '0;
    bus_resptag = '0;
    n = 0;
    @(posedge clk);
    while (reset && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (reset) begin
      $display("reset still asserted after %0d cycles", n);
      stalled = 1'b1;
    end
    while (!finish_run && !stalled) begin
      n = 0;
      while (!bus_reqcyc && !finish_run && n < idle_limit) begin
        @(posedge clk);
        n++;
      end
      if (n >= idle_limit) begin
        $display("memory model saw no bus request for %0d cycles", idle_limit);
        stalled = 1'b1;
        break;
      end
      if (finish_run) break;
      addr = bus_req;
      tag  = bus_reqtag;
      d = 1 + draw() % 4;              // ack latency 1 to 4 cycles
      repeat (d - 1) @(posedge clk);
      bus_reqack <= 1'b1;
      @(posedge clk);
      bus_reqack <= 1'b0;
      for (int k = 0; k < 8; k++) begin
        g = draw() % 3;
        if (g > 0) begin
          bus_respcyc <= 1'b0;         // idle gap between beats
          repeat (g) @(posedge clk);
        end
        bus_respcyc <= 1'b1;
        bus_resp    <= {mem_word(addr + 8 * k + 4), mem_word(addr + 8 * k)};
        bus_resptag <= tag;
        @(posedge clk);
      end
      bus_respcyc <= 1'b0;
    end
  end

  initial begin
    int n;
    reset = 1'b1;
    entry = prog_base;
    finish_run = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    n = 0;
    while (retires < num_retires && !stalled && n < run_limit) begin
      @(posedge clk);
      n++;
    end
    if (stalled || n >= run_limit) begin
      if (!stalled) $display("run did not reach %0d retires in %0d cycles", num_retires, n);
      $display("RESULT: FAIL");
    end else begin
      finish_run <= 1'b1;
      n = 0;
      while (!report_done && n < 100) begin
        @(posedge clk);
        n++;
      end
      if (!report_done) begin
        $display("checker did not produce its report");
        $display("RESULT: FAIL");
      end else if (errors == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
    end
    $finish;
  end

endmodule

/* bench/core_checker.sv */
`timescale 1ns/1ps
module core_checker #(
  parameter int cache_lines = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic [63:0] entry,
  input  logic bus_reqcyc,
  input  logic bus_respack,
  input  logic [63:0] bus_req,
  input  logic [12:0] bus_reqtag,
  input  logic bus_respcyc,
  input  logic retire_valid,
  input  logic [63:0] retire_pc,
  input  logic [31:0] retire_inst,
  input  logic [4:0] retire_rd,
  input  logic retire_we,
  input  logic [63:0] retire_data,
  input  logic [31:0] prog [512],
  input  logic finish_run,
  output int retires,
  output int errors,
  output logic report_done
);

  localparam int hit_gap = 4;  // retire, hit, decode, execute, retire
  localparam string names [1:6] = '{"reset state", "arithmetic and logic", "x0 and no-ops",
                                    "control flow", "refill", "hit timing"};

  logic [63:0] regs [32];
  logic [63:0] exp_pc, shadow_tag [cache_lines];
  logic [cache_lines-1:0] shadow_valid = '0;
  logic in_reset = 1'b1, prev_reqcyc = 1'b0, seen_req = 1'b0, req_since = 1'b0;
  logic reported = 1'b0, first_retire = 1'b1;
  int checks [1:6] = '{0, 0, 0, 0, 0, 0};
  int errs [1:6] = '{0, 0, 0, 0, 0, 0};
  int cycle = 0, last_retire = 0, beat_cnt = 0, retire_cnt = 0, err_total = 0;

  assign errors = err_total;

  task automatic report_error(input int t, input string msg);
    $display("Error at %0t: test %0d, %s", $time, t, msg);
    errs[t]++;
    err_total++;
  endtask

  // ISA reference for the supported subset, anything else is a no-op
  task automatic model_step(input logic [31:0] w, input logic [63:0] pc, output logic we,
                            output logic [63:0] data, output logic [63:0] npc);
    logic [63:0] a, b, ii, iu, ij;
    a  = regs[w[19:15]];
    b  = regs[w[24:20]];
    ii = {{52{w[31]}}, w[31:20]};
    iu = {{32{w[31]}}, w[31:12], 12'b0};
    ij = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    we = 1'b1;
    data = '0;
    npc = pc + 4;
    case (w[6:0])
      7'b0110111: data = iu;
      7'b0010111: data = pc + iu;
      7'b1101111: begin
        data = pc + 4;
        npc  = pc + ij;
      end
      7'b0010011: case (w[14:12])
        3'd0: data = a + ii;
        3'd2: data = 64'($signed(a) < $signed(ii));
        3'd3: data = 64'(a < ii);
        3'd4: data = a ^ ii;
        3'd6: data = a | ii;
        3'd7: data = a & ii;
        3'd1: if (w[31:26] == 6'd0) data = a << w[25:20]; else we = 1'b0;
        default: if (w[31:26] == 6'd0) data = a >> w[25:20];
          else if (w[31:26] == 6'b010000) data = $signed(a) >>> w[25:20];
          else we = 1'b0;
      endcase
      7'b0110011: case ({w[31:25], w[14:12]})
        10'h000: data = a + b;
        10'h100: data = a - b;
        10'h001: data = a << b[5:0];
        10'h002: data = 64'($signed(a) < $signed(b));
        10'h003: data = 64'(a < b);
        10'h004: data = a ^ b;
        10'h005: data = a >> b[5:0];
        10'h105: data = $signed(a) >>> b[5:0];
        10'h006: data = a | b;
        10'h007: data = a & b;
        default: we = 1'b0;
      endcase
      default: we = 1'b0;
    endcase
  endtask

  task automatic watch_bus();
    logic [63:0] line;
    int idx;
    if (bus_respcyc && bus_respack) beat_cnt++;
    if (bus_reqcyc && !prev_reqcyc) begin  // start of a new request
      line = bus_req >> 6;
      idx  = int'(line % cache_lines);
      if (!seen_req) begin
        checks[1]++;
        if (bus_req !== (entry & ~64'h3f) || bus_reqtag !== core_pkg::bus_tag_read)
          report_error(1, $sformatf("first request %h tag %h", bus_req, bus_reqtag));
        seen_req = 1'b1;
      end else begin
        checks[5]++;
        if (beat_cnt != 8)
          report_error(5, $sformatf("previous refill had %0d beats", beat_cnt));
      end
      checks[5]++;
      if (bus_req[5:0] != 6'd0)
        report_error(5, $sformatf("request %h not line aligned", bus_req));
      if (bus_reqtag !== core_pkg::bus_tag_read)
        report_error(5, $sformatf("request %h carries tag %h", bus_req, bus_reqtag));
      if (shadow_valid[idx] && shadow_tag[idx] == line / cache_lines)
        report_error(5, $sformatf("refill of cached line %h", bus_req));
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx]   = line / cache_lines;
      beat_cnt  = 0;
      req_since = 1'b1;
    end
  endtask

  task automatic check_retire();
    logic [31:0] word;
    logic [63:0] data, npc;
    logic we;
    int t;
    checks[4]++;
    if (retire_pc !== exp_pc)
      report_error(4, $sformatf("retire_pc %h, expected %h", retire_pc, exp_pc));
    word = (exp_pc >= entry && exp_pc < entry + 2048) ? prog[(exp_pc - entry) >> 2] : 32'b0;
    if (retire_inst !== word)
      report_error(4, $sformatf("retire_inst %h, expected %h", retire_inst, word));
    model_step(word, exp_pc, we, data, npc);
    if (!we) begin
      checks[3]++;
      if (retire_we !== 1'b0) report_error(3, $sformatf("unknown word %h retired with a write", word));
    end else begin
      t = (word[11:7] == 5'd0) ? 3 : 2;
      checks[t]++;
      if (retire_we !== 1'b1 || retire_rd !== word[11:7] || retire_data !== data)
        report_error(t, $sformatf("inst %h wrote x%0d %h, expected x%0d %h",
                                  word, retire_rd, retire_data, word[11:7], data));
      if (word[11:7] != 5'd0) regs[word[11:7]] = data;  // x0 stays zero
    end
    exp_pc = npc;
    if (!first_retire && !req_since) begin
      checks[6]++;
      if (cycle - last_retire != hit_gap)
        report_error(6, $sformatf("hit retire gap %0d cycles", cycle - last_retire));
    end
    first_retire = 1'b0;
    req_since = 1'b0;
    last_retire = cycle;
    retire_cnt++;
  endtask

  task automatic print_report();
    int total;
    total = 0;
    if (!seen_req) report_error(1, "no bus request seen after reset");
    for (int t = 1; t <= 6; t++) begin
      $display("test %0d %s: %s (%0d checks, %0d errors)", t, names[t],
               (errs[t] == 0) ? "ok" : "failed", checks[t], errs[t]);
      total += checks[t];
    end
    $display("counts: %0d retires, %0d checks, %0d errors", retire_cnt, total, err_total);
  endtask

  initial begin
    for (int i = 0; i < 32; i++) regs[i] = '0;
  end

  always @(posedge clk) begin
    cycle++;
    if (reset) begin
      in_reset = 1'b1;
      exp_pc = entry;
    end else begin
      if (in_reset) begin  // first cycle out of reset, everything idle
        checks[1]++;
        if (bus_reqcyc !== 1'b0 || bus_respack !== 1'b0 || retire_valid !== 1'b0)
          report_error(1, "outputs not idle after reset");
      end
      in_reset = 1'b0;
      watch_bus();
      if (retire_valid) check_retire();
      if (finish_run && !reported) begin
        print_report();
        reported = 1'b1;
      end
    end
    prev_reqcyc = bus_reqcyc;
    retires     <= retire_cnt;
    report_done <= reported;
  end

endmodule

/* hdl/core_top.sv */
`timescale 1ns/1ps
module core_top #(
  parameter int cache_lines    = 8,
  parameter int bus_tag_width  = 13,
  parameter int bus_data_width = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic [core_pkg::xlen-1:0] entry,   // program entry point
  output logic bus_reqcyc,
  output logic bus_respack,
  output logic [bus_data_width-1:0] bus_req,
  output logic [bus_tag_width-1:0] bus_reqtag,
  input  logic bus_respcyc,
  input  logic bus_reqack,
  input  logic [bus_data_width-1:0] bus_resp,
  input  logic [bus_tag_width-1:0] bus_resptag,
  output logic retire_valid,
  output logic [core_pkg::xlen-1:0] retire_pc,
  output logic [core_pkg::inst_width-1:0] retire_inst,
  output logic [4:0] retire_rd,
  output logic retire_we,
  output logic [core_pkg::xlen-1:0] retire_data
);

  // refill path
  logic fill_req, fill_done;
  logic [core_pkg::xlen-1:0] fill_addr;
  logic [core_pkg::line_bits-1:0] fill_line;
  // fetch path
  logic fetch_req, inst_valid;
  logic [core_pkg::xlen-1:0] fetch_pc, inst_pc;
  logic [core_pkg::inst_width-1:0] inst;
  // decode to execute
  logic dec_valid, dec_use_imm, dec_we;
  logic [core_pkg::xlen-1:0] dec_a, dec_b, dec_imm, dec_pc;
  core_pkg::alu_op_t dec_op;
  logic [4:0] dec_rd;
  logic [core_pkg::inst_width-1:0] dec_inst, ex_inst;   // instruction word rides along
  // execute to writeback, writeback to register file
  logic ex_valid, ex_we, wb_we;
  logic [core_pkg::xlen-1:0] ex_result, ex_next_pc, ex_pc, wb_data;
  logic [4:0] ex_rd, wb_rd;

  bus_controller #(
    .bus_tag_width(bus_tag_width),
    .bus_data_width(bus_data_width)
  ) i_bus_controller (.*);

  icache #(.cache_lines(cache_lines)) i_icache (.*);

  decode_regfile i_decode_regfile (.*);

  alu i_alu (.*);

  writeback i_writeback (.*);

endmodule

/* hdl/writeback.sv */
`timescale 1ns/1ps
module writeback (
  input  logic clk,
  input  logic reset,
  input  logic [core_pkg::xlen-1:0] entry,
  input  logic ex_valid,
  input  logic [core_pkg::xlen-1:0] ex_result,
  input  logic [4:0] ex_rd,
  input  logic ex_we,
  input  logic [core_pkg::xlen-1:0] ex_next_pc,
  input  logic [core_pkg::xlen-1:0] ex_pc,
  input  logic [core_pkg::inst_width-1:0] ex_inst,
  output logic wb_we,
  output logic [4:0] wb_rd,
  output logic [core_pkg::xlen-1:0] wb_data,
  output logic fetch_req,
  output logic [core_pkg::xlen-1:0] fetch_pc,
  output logic retire_valid,
  output logic [core_pkg::xlen-1:0] retire_pc,
  output logic [core_pkg::inst_width-1:0] retire_inst,
  output logic [4:0] retire_rd,
  output logic retire_we,
  output logic [core_pkg::xlen-1:0] retire_data
);

  logic [core_pkg::xlen-1:0] pc;
  logic in_flight;                    // fetched, not yet through execute

  assign fetch_pc = pc;               // pc already holds the committed next pc
  assign wb_we    = retire_valid & retire_we;
  assign wb_rd    = retire_rd;
  assign wb_data  = retire_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc           <= entry;
      fetch_req    <= 1'b1;           // first fetch goes out as reset drops
      retire_valid <= 1'b0;
      in_flight    <= 1'b0;
    end else begin
      fetch_req    <= ex_valid;
      retire_valid <= ex_valid;
      in_flight    <= fetch_req | (in_flight & ~ex_valid);
      if (ex_valid) pc <= ex_next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      retire_pc   <= ex_pc;
      retire_inst <= ex_inst;
      retire_rd   <= ex_rd;
      retire_we   <= ex_we;
      retire_data <= ex_result;
    end
  end

  a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
    fetch_req |-> !in_flight);

  a_ex_has_fetch: assert property (@(posedge clk) disable iff (reset)
    ex_valid |-> in_flight);

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps
module alu (
  input  logic clk,
  input  logic reset,
  input  logic dec_valid,
  input  logic [core_pkg::xlen-1:0] dec_a,
  input  logic [core_pkg::xlen-1:0] dec_b,
  input  logic [core_pkg::xlen-1:0] dec_imm,
  input  core_pkg::alu_op_t dec_op,
  input  logic dec_use_imm,
  input  logic [4:0] dec_rd,
  input  logic dec_we,
  input  logic [core_pkg::xlen-1:0] dec_pc,
  input  logic [core_pkg::inst_width-1:0] dec_inst,
  output logic ex_valid,
  output logic [core_pkg::xlen-1:0] ex_result,
  output logic [4:0] ex_rd,
  output logic ex_we,
  output logic [core_pkg::xlen-1:0] ex_next_pc,
  output logic [core_pkg::xlen-1:0] ex_pc,
  output logic [core_pkg::inst_width-1:0] ex_inst
);

  logic [core_pkg::xlen-1:0] b, result, next_pc;
  logic [5:0] shamt;

  assign b       = dec_use_imm ? dec_imm : dec_b;   // I-type forms take the immediate
  assign shamt   = b[5:0];
  assign next_pc = (dec_op == core_pkg::alu_jal) ? dec_pc + dec_imm : dec_pc + 64'd4;

  always_comb begin
    case (dec_op)
      core_pkg::alu_add:   result = dec_a + b;
      core_pkg::alu_sub:   result = dec_a - b;
      core_pkg::alu_sll:   result = dec_a << shamt;
      core_pkg::alu_slt:   result = {63'b0, $signed(dec_a) < $signed(b)};
      core_pkg::alu_sltu:  result = {63'b0, dec_a < b};
      core_pkg::alu_xor:   result = dec_a ^ b;
      core_pkg::alu_srl:   result = dec_a >> shamt;
      core_pkg::alu_sra:   result = $signed(dec_a) >>> shamt;
      core_pkg::alu_or:    result = dec_a | b;
      core_pkg::alu_and:   result = dec_a & b;
      core_pkg::alu_lui:   result = dec_imm;
      core_pkg::alu_auipc: result = dec_pc + dec_imm;
      core_pkg::alu_jal:   result = dec_pc + 64'd4;   // link address
      default:             result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) ex_valid <= 1'b0;
    else       ex_valid <= dec_valid;
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ex_result  <= result;
      ex_rd      <= dec_rd;
      ex_we      <= dec_we;
      ex_next_pc <= next_pc;
      ex_pc      <= dec_pc;
      ex_inst    <= dec_inst;
    end
  end

endmodule

/* hdl/decode_regfile.sv */
`timescale 1ns/1ps
module decode_regfile (
  input  logic clk,
  input  logic reset,
  input  logic inst_valid,
  input  logic [core_pkg::inst_width-1:0] inst,
  input  logic [core_pkg::xlen-1:0] inst_pc,
  input  logic wb_we,
  input  logic [4:0] wb_rd,
  input  logic [core_pkg::xlen-1:0] wb_data,
  output logic dec_valid,
  output logic [core_pkg::xlen-1:0] dec_a,
  output logic [core_pkg::xlen-1:0] dec_b,
  output logic [core_pkg::xlen-1:0] dec_imm,
  output core_pkg::alu_op_t dec_op,
  output logic dec_use_imm,
  output logic [4:0] dec_rd,
  output logic dec_we,
  output logic [core_pkg::xlen-1:0] dec_pc,
  output logic [core_pkg::inst_width-1:0] dec_inst
);

  logic [core_pkg::xlen-1:0] regs [32];   // x0 slot never written
  core_pkg::major_op_t major;
  core_pkg::alu_op_t op;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rs1, rs2;
  logic [core_pkg::xlen-1:0] imm_i, imm_u, imm_j, imm;
  logic use_imm;

  assign major  = core_pkg::major_op_t'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign imm_i  = {{52{inst[31]}}, inst[31:20]};
  assign imm_u  = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j  = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    op      = core_pkg::alu_nop;   // anything unmatched retires as a no-op
    imm     = imm_i;
    use_imm = 1'b0;
    case (major)
      core_pkg::op_lui: begin
        op  = core_pkg::alu_lui;
        imm = imm_u;
      end
      core_pkg::op_auipc: begin
        op  = core_pkg::alu_auipc;
        imm = imm_u;
      end
      core_pkg::op_jal: begin
        op  = core_pkg::alu_jal;
        imm = imm_j;
      end
      core_pkg::op_imm: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000: op = core_pkg::alu_add;
          3'b010: op = core_pkg::alu_slt;
          3'b011: op = core_pkg::alu_sltu;
          3'b100: op = core_pkg::alu_xor;
          3'b110: op = core_pkg::alu_or;
          3'b111: op = core_pkg::alu_and;
          3'b001: if (inst[31:26] == 6'b000000) op = core_pkg::alu_sll;  // 6-bit shamt
          default: begin  // 101 holds srli and srai
            if (inst[31:26] == 6'b000000) op = core_pkg::alu_srl;
            else if (inst[31:26] == 6'b010000) op = core_pkg::alu_sra;
          end
        endcase
      end
      core_pkg::op_reg: begin
        case ({funct7, funct3})
          10'b0000000_000: op = core_pkg::alu_add;
          10'b0100000_000: op = core_pkg::alu_sub;
          10'b0000000_001: op = core_pkg::alu_sll;
          10'b0000000_010: op = core_pkg::alu_slt;
          10'b0000000_011: op = core_pkg::alu_sltu;
          10'b0000000_100: op = core_pkg::alu_xor;
          10'b0000000_101: op = core_pkg::alu_srl;
          10'b0100000_101: op = core_pkg::alu_sra;
          10'b0000000_110: op = core_pkg::alu_or;
          10'b0000000_111: op = core_pkg::alu_and;
          default: op = core_pkg::alu_nop;
        endcase
      end
      default: op = core_pkg::alu_nop;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wb_we && wb_rd != 5'd0) regs[wb_rd] <= wb_data;  // lands before the next decode
  end

  always_ff @(posedge clk) begin
    if (reset) dec_valid <= 1'b0;
    else       dec_valid <= inst_valid;
  end

  always_ff @(posedge clk) begin
    if (inst_valid) begin
      dec_a       <= (rs1 == 5'd0) ? '0 : regs[rs1];
      dec_b       <= (rs2 == 5'd0) ? '0 : regs[rs2];
      dec_imm     <= imm;
      dec_op      <= op;
      dec_use_imm <= use_imm;
      dec_rd      <= inst[11:7];
      dec_we      <= (op != core_pkg::alu_nop);
      dec_pc      <= inst_pc;
      dec_inst    <= inst;
    end
  end

endmodule

/* hdl/icache.sv */
`timescale 1ns/1ps
module icache #(
  parameter int cache_lines = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic fetch_req,
  input  logic [core_pkg::xlen-1:0] fetch_pc,
  output logic inst_valid,
  output logic [core_pkg::inst_width-1:0] inst,
  output logic [core_pkg::xlen-1:0] inst_pc,
  output logic fill_req,
  output logic [core_pkg::xlen-1:0] fill_addr,
  input  logic fill_done,
  input  logic [core_pkg::line_bits-1:0] fill_line
);

  localparam int index_bits = $clog2(cache_lines);
  localparam int word_bits  = $clog2(core_pkg::line_bytes / 4);  // 32-bit words per line
  localparam int tag_bits   = core_pkg::xlen - core_pkg::offset_bits - index_bits;

  typedef enum logic {ic_idle, ic_fill} state_t;

  state_t state;
  logic [cache_lines-1:0] valid_bits;
  logic [tag_bits-1:0] tag_mem [cache_lines];
  logic [core_pkg::line_bits-1:0] data_mem [cache_lines];
  logic [core_pkg::xlen-1:0] req_pc;           // pc of the fetch being served
  logic [index_bits-1:0] idx, req_idx;
  logic [tag_bits-1:0] tag;
  logic [word_bits-1:0] word, req_word;
  logic hit;
  logic outstanding;

  assign idx      = fetch_pc[core_pkg::offset_bits +: index_bits];
  assign tag      = fetch_pc[core_pkg::xlen-1 -: tag_bits];
  assign word     = fetch_pc[2 +: word_bits];
  assign req_idx  = req_pc[core_pkg::offset_bits +: index_bits];
  assign req_word = req_pc[2 +: word_bits];
  assign hit      = valid_bits[idx] && (tag_mem[idx] == tag);
  assign fill_addr = {req_pc[core_pkg::xlen-1:core_pkg::offset_bits],
                      {core_pkg::offset_bits{1'b0}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ic_idle;
      valid_bits  <= '0;
      inst_valid  <= 1'b0;
      fill_req    <= 1'b0;
      outstanding <= 1'b0;
    end else begin
      inst_valid  <= 1'b0;
      fill_req    <= 1'b0;
      outstanding <= fetch_req | (outstanding & ~inst_valid);
      case (state)
        ic_idle: if (fetch_req) begin
          if (hit) begin
            inst_valid <= 1'b1;                 // hit answers next cycle
          end else begin
            fill_req <= 1'b1;
            state    <= ic_fill;
          end
        end
        ic_fill: if (fill_done) begin
          valid_bits[req_idx] <= 1'b1;          // replaces whatever lived at this index
          inst_valid          <= 1'b1;
          state               <= ic_idle;
        end
        default: state <= ic_idle;
      endcase
    end
  end

  // arrays and output payload
  always_ff @(posedge clk) begin
    if (fetch_req && state == ic_idle) begin
      req_pc  <= fetch_pc;
      inst_pc <= fetch_pc;
      inst    <= data_mem[idx][word*core_pkg::inst_width +: core_pkg::inst_width];
    end
    if (fill_done && state == ic_fill) begin
      tag_mem[req_idx]  <= req_pc[core_pkg::xlen-1 -: tag_bits];
      data_mem[req_idx] <= fill_line;
      inst <= fill_line[req_word*core_pkg::inst_width +: core_pkg::inst_width];  // bypass
    end
  end

  a_inst_outstanding: assert property (@(posedge clk) disable iff (reset)
    inst_valid |-> outstanding);

endmodule

/* hdl/bus_controller.sv */
`timescale 1ns/1ps
module bus_controller #(
  parameter int bus_tag_width  = 13,
  parameter int bus_data_width = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic fill_req,                            // one-cycle strobe from icache
  input  logic [core_pkg::xlen-1:0] fill_addr,
  output logic fill_done,
  output logic [core_pkg::line_bits-1:0] fill_line,
  output logic bus_reqcyc,
  output logic bus_respack,
  output logic [bus_data_width-1:0] bus_req,
  output logic [bus_tag_width-1:0] bus_reqtag,
  input  logic bus_respcyc,
  input  logic bus_reqack,
  input  logic [bus_data_width-1:0] bus_resp,
  input  logic [bus_tag_width-1:0] bus_resptag
);

  typedef enum logic [1:0] {st_idle, st_request, st_collect} state_t;

  localparam int cnt_bits = $clog2(core_pkg::line_beats);
  localparam logic [cnt_bits-1:0] last_beat = cnt_bits'(core_pkg::line_beats - 1);

  state_t state;
  logic [cnt_bits-1:0] beat_cnt;                  // beats taken so far in this line
  logic [core_pkg::line_bits-1:0] line_buf;
  logic [bus_data_width-1:0] req_addr;
  logic beat;

  assign beat        = (state == st_collect) && bus_respcyc;  // never stall the responder
  assign bus_reqcyc  = (state == st_request);
  assign bus_respack = beat;                                   // ack in the beat's own cycle
  assign bus_req     = req_addr;
  assign bus_reqtag  = bus_tag_width'(core_pkg::bus_tag_read);
  assign fill_line   = line_buf;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      beat_cnt  <= '0;
      fill_done <= 1'b0;
    end else begin
      fill_done <= 1'b0;
      case (state)
        st_idle: if (fill_req) state <= st_request;       // request goes out next cycle
        st_request: begin
          beat_cnt <= '0;
          if (bus_reqack) state <= st_collect;            // reqcyc drops after the ack cycle
        end
        st_collect: if (beat) begin
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == last_beat) begin
            state     <= st_idle;
            fill_done <= 1'b1;                            // line complete, strobe once
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fill_req && state == st_idle)   // line-aligned address, held for the whole request
      req_addr <= bus_data_width'({fill_addr[core_pkg::xlen-1:core_pkg::offset_bits],
                                   {core_pkg::offset_bits{1'b0}}});
    if (beat)  // beats arrive in address order, first lands in the low word
      line_buf <= {bus_resp, line_buf[core_pkg::line_bits-1:bus_data_width]};
  end

  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    bus_reqcyc && !bus_reqack |=> bus_reqcyc && $stable(bus_req) && $stable(bus_reqtag));

  a_fill_idle: assert property (@(posedge clk) disable iff (reset)
    fill_req |-> state == st_idle);

  // responder echoes the request tag on every beat
  a_resp_tag: assert property (@(posedge clk) disable iff (reset)
    bus_respack |-> bus_resptag == bus_reqtag);

endmodule

/* hdl/core_pkg.sv */
package core_pkg;

  localparam int xlen        = 64;  // integer register and address width
  localparam int inst_width  = 32;
  localparam int line_bytes  = 64;
  localparam int line_bits   = line_bytes * 8;
  localparam int line_beats  = 8;   // 64-bit bus beats per cache line
  localparam int offset_bits = $clog2(line_bytes);

  // request tag: read flag, memory target nibble, zero low byte
  localparam logic [12:0] bus_tag_read = 13'b1_0001_0000_0000;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011,
    op_jal   = 7'b1101111
  } major_op_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_lui,    // result is the U immediate
    alu_auipc,  // pc + U immediate
    alu_jal,    // link value, pc + 4
    alu_nop     // unsupported word, no write
  } alu_op_t;

endpackage
